/* project.f */
verilog/frame_pkg.sv
verilog/mem_port_if.sv
verilog/pixel_fifo.sv
verilog/frame_writer.sv
verilog/frame_store.sv
verilog/frame_reader.sv
verilog/frame_buffer.sv
bench/frame_buffer_checker.sv
bench/frame_buffer_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module frame_buffer_tb -f project.f -o frame_buffer_sim
	@out="$$(./obj_dir/frame_buffer_sim)"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

/* bench/frame_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb;

	localparam int FRAME_PIXELS = 64;
	localparam int FIFO_DEPTH = 8;
	localparam int WAIT_CYCLES = 2;
	// Three frames written and four read over the whole run
	localparam int FRAMES = 7;
	localparam longint TIMEOUT_NS =
		longint'(FRAMES) * FRAME_PIXELS * (WAIT_CYCLES + 8) * 20 + 10000;

	logic ctrl_clk;
	logic reset_n;
	logic in_valid;
	frame_pkg::pixel_t in_data;
	logic in_ready;
	logic rd_start;
	logic out_valid;
	frame_pkg::pixel_t out_data;
	logic out_ready;
	logic frame_written;
	logic frame_read_done;

	int chk_errors;
	int in_words;
	int out_words;
	int written_pulses;
	int done_pulses;
	int tb_errors;
	int errors_at_start;
	logic saw_stall;

	frame_buffer #(
		.FRAME_PIXELS(FRAME_PIXELS),
		.FIFO_DEPTH(FIFO_DEPTH),
		.WAIT_CYCLES(WAIT_CYCLES)
	) DUT (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.rd_start(rd_start),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready),
		.frame_written(frame_written),
		.frame_read_done(frame_read_done)
	);

	frame_buffer_checker #(
		.FRAME_PIXELS(FRAME_PIXELS)
	) watch (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.rd_start(rd_start),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready),
		.frame_written(frame_written),
		.frame_read_done(frame_read_done),
		.errors(chk_errors),
		.in_words(in_words),
		.out_words(out_words),
		.written_pulses(written_pulses),
		.done_pulses(done_pulses)
	);

	always #10 ctrl_clk = ~ctrl_clk;

	task automatic compare_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			tb_errors++;
		end
	endtask

	task automatic end_test(input string name);
		int found;
		found = chk_errors + tb_errors - errors_at_start;
		if (found == 0)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, found);
		errors_at_start = chk_errors + tb_errors;
	endtask

	// Push one frame of random pixels, holding each word until accepted
	task automatic send_frame(input logic burst, input int frames_done);
		int sent;
		logic accepted;
		sent = 0;
		saw_stall = 1'b0;
		while (sent < FRAME_PIXELS) begin
			@(posedge ctrl_clk);
			accepted = in_valid && in_ready;
			if (in_valid && !in_ready)
				saw_stall = 1'b1;
			if (accepted)
				sent++;
			if (sent == FRAME_PIXELS) begin
				in_valid <= 1'b0;
			end else if (accepted || !in_valid) begin
				in_valid <= burst || ($urandom_range(99, 0) < 60);
				in_data <= $urandom();
			end
		end
		while (written_pulses < frames_done)
			@(posedge ctrl_clk);
		repeat (10) @(posedge ctrl_clk);
		compare_count("frame_written pulses", written_pulses, frames_done);
	endtask

	task automatic read_frame(input logic gaps, input int frames_done);
		@(posedge ctrl_clk);
		rd_start <= 1'b1;
		@(posedge ctrl_clk);
		rd_start <= 1'b0;
		while (done_pulses < frames_done || out_words < frames_done * FRAME_PIXELS) begin
			out_ready <= gaps ? ($urandom_range(99, 0) < 50) : 1'b1;
			@(posedge ctrl_clk);
		end
		out_ready <= 1'b1;
		// Idle stretch where the checker catches any extra out_valid
		repeat (20) @(posedge ctrl_clk);
		compare_count("frame_read_done pulses", done_pulses, frames_done);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hd63b01fc));
		ctrl_clk = 1'b0;
		reset_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		rd_start = 1'b0;
		out_ready = 1'b0;
		tb_errors = 0;
		errors_at_start = 0;
		repeat (3) @(posedge ctrl_clk);
		reset_n <= 1'b1;

		repeat (8) @(posedge ctrl_clk);
		end_test("reset state");

		send_frame(1'b0, 1);
		end_test("write frame with input gaps");

		read_frame(1'b0, 1);
		end_test("read frame, out_ready high");

		read_frame(1'b1, 2);
		end_test("read frame with output gaps");

		send_frame(1'b0, 2);
		read_frame(1'b0, 3);
		end_test("second frame after address wrap");

		send_frame(1'b1, 3);
		if (!saw_stall) begin
			$display("The input burst never saw in_ready go low");
			tb_errors++;
		end
		read_frame(1'b1, 4);
		end_test("input burst with back-pressure");

		$display("Tests 6, words in %0d out %0d, frames written %0d read %0d, errors %0d",
			in_words, out_words, written_pulses, done_pulses, chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/frame_buffer_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_checker #(
	parameter int FRAME_PIXELS = 64
) (
	input wire logic ctrl_clk,
	input wire logic reset_n,
	input wire logic in_valid,
	input wire frame_pkg::pixel_t in_data,
	input wire logic in_ready,
	input wire logic rd_start,
	input wire logic out_valid,
	input wire frame_pkg::pixel_t out_data,
	input wire logic out_ready,
	input wire logic frame_written,
	input wire logic frame_read_done,
	output int errors,
	output int in_words,
	output int out_words,
	output int written_pulses,
	output int done_pulses
);

	// Frame being written, and the last complete frame
	frame_pkg::pixel_t pending [FRAME_PIXELS];
	frame_pkg::pixel_t model [FRAME_PIXELS];
	int starts;
	int fails;
	logic active;

	task automatic check_level(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
			fails++;
		end
	endtask

	always @(posedge ctrl_clk) begin
		fails = 0;
		if (!reset_n) begin
			errors <= 0;
			in_words <= 0;
			out_words <= 0;
			written_pulses <= 0;
			done_pulses <= 0;
			starts <= 0;
			active <= 1'b0;
		end else begin
			// Nothing driven yet so outputs sit at their reset values
			if (!active) begin
				check_level("in_ready", in_ready, 1'b1);
				check_level("out_valid", out_valid, 1'b0);
				check_level("frame_written", frame_written, 1'b0);
				check_level("frame_read_done", frame_read_done, 1'b0);
			end
			if (in_valid || rd_start)
				active <= 1'b1;
			if (rd_start)
				starts <= starts + 1;

			if (in_valid && in_ready) begin
				pending[in_words % FRAME_PIXELS] <= in_data;
				in_words <= in_words + 1;
			end

			// New frame becomes the reference once it is fully stored
			if (frame_written) begin
				if (in_words < (written_pulses + 1) * FRAME_PIXELS) begin
					$display("At %0t frame_written came before a whole frame was accepted", $time);
					fails++;
				end
				for (int i = 0; i < FRAME_PIXELS; i++)
					model[i] <= pending[i];
				written_pulses <= written_pulses + 1;
			end

			if (out_valid && out_words >= starts * FRAME_PIXELS) begin
				$display("At %0t out_valid is high although no frame word is left to read", $time);
				fails++;
			end else if (out_valid && out_ready) begin
				if (out_data !== model[out_words % FRAME_PIXELS]) begin
					$display("Fail at %0t: out_data expected %08h, got %08h", $time,
						model[out_words % FRAME_PIXELS], out_data);
					fails++;
				end
				out_words <= out_words + 1;
			end

			if (frame_read_done) begin
				if (done_pulses >= starts) begin
					$display("At %0t frame_read_done pulsed with no read in progress", $time);
					fails++;
				end
				done_pulses <= done_pulses + 1;
			end

			errors <= errors + fails;
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
	parameter int FRAME_PIXELS = 64,
	parameter int FIFO_DEPTH = 8,
	parameter int WAIT_CYCLES = 2
) (
	input wire logic ctrl_clk,
	input wire logic reset_n,
	input wire logic in_valid,
	input wire frame_pkg::pixel_t in_data,
	output logic in_ready,
	input wire logic rd_start,
	output logic out_valid,
	output frame_pkg::pixel_t out_data,
	input wire logic out_ready,
	output logic frame_written,
	output logic frame_read_done
);

	localparam int FW = $clog2(FIFO_DEPTH + 1);

	// Input FIFO to writer
	logic wr_pix_valid;
	frame_pkg::pixel_t wr_pix_data;
	logic wr_pix_ready;

	// Reader to output FIFO
	logic rd_push_valid;
	frame_pkg::pixel_t rd_push_data;
	logic rd_push_ready;
	logic [FW-1:0] out_free_words;

	mem_port_if wr_port ();
	mem_port_if rd_port ();

	pixel_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) in_fifo (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.push_valid(in_valid),
		.push_data(in_data),
		.push_ready(in_ready),
		.pop_valid(wr_pix_valid),
		.pop_data(wr_pix_data),
		.pop_ready(wr_pix_ready),
		.free_words()
	);

	frame_writer #(
		.FRAME_PIXELS(FRAME_PIXELS)
	) frame_writer (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.pix_valid(wr_pix_valid),
		.pix_data(wr_pix_data),
		.pix_ready(wr_pix_ready),
		.mem(wr_port.requester),
		.frame_written(frame_written)
	);

	frame_store #(
		.FRAME_PIXELS(FRAME_PIXELS),
		.WAIT_CYCLES(WAIT_CYCLES)
	) frame_store (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.wr(wr_port.store),
		.rd(rd_port.store)
	);

	frame_reader #(
		.FRAME_PIXELS(FRAME_PIXELS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) frame_reader (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.rd_start(rd_start),
		.mem(rd_port.requester),
		.push_valid(rd_push_valid),
		.push_data(rd_push_data),
		.push_ready(rd_push_ready),
		.free_words(out_free_words),
		.frame_read_done(frame_read_done)
	);

	pixel_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) out_fifo (
		.ctrl_clk(ctrl_clk),
		.reset_n(reset_n),
		.push_valid(rd_push_valid),
		.push_data(rd_push_data),
		.push_ready(rd_push_ready),
		.pop_valid(out_valid),
		.pop_data(out_data),
		.pop_ready(out_ready),
		.free_words(out_free_words)
	);

endmodule

`default_nettype wire

/* verilog/frame_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_reader #(
	parameter int FRAME_PIXELS = 64,
	parameter int FIFO_DEPTH = 8
) (
	input wire logic ctrl_clk,
	input wire logic reset_n,
	input wire logic rd_start,
	mem_port_if.requester mem,
	output logic push_valid,
	output frame_pkg::pixel_t push_data,
	input wire logic push_ready,
	input wire logic [$clog2(FIFO_DEPTH + 1)-1:0] free_words,
	output logic frame_read_done
);

	frame_pkg::reader_state_t state;
	frame_pkg::addr_t addr;
	logic last_addr;
	logic read_done;

	assign last_addr = addr == frame_pkg::addr_t'(FRAME_PIXELS - 1);
	assign read_done = mem.read & ~mem.waitrequest;

	// Read-only side of the store
	assign mem.addr = addr;
	assign mem.write = 1'b0;
	assign mem.wdata = '0;

	always_ff @(posedge ctrl_clk) begin
		if (!reset_n) begin
			state <= frame_pkg::state_idle;
			addr <= '0;
			mem.read <= 1'b0;
			push_valid <= 1'b0;
			frame_read_done <= 1'b0;
		end else begin
			frame_read_done <= 1'b0;

			case (state)
				frame_pkg::state_idle: begin
					if (rd_start) begin
						addr <= '0;
						state <= frame_pkg::state_request;
					end
				end

				frame_pkg::state_request: begin
					if (!mem.read) begin
						// Only read when the word has a slot waiting in the FIFO
						if (free_words != '0)
							mem.read <= 1'b1;
					end else if (read_done) begin
						mem.read <= 1'b0;
						push_valid <= 1'b1;
						state <= frame_pkg::state_advance;
					end
				end

				frame_pkg::state_advance: begin
					if (push_ready) begin
						push_valid <= 1'b0;
						if (last_addr) begin
							frame_read_done <= 1'b1;
							state <= frame_pkg::state_idle;
						end else begin
							addr <= addr + 1'b1;
							state <= frame_pkg::state_request;
						end
					end
				end

				default: begin
					mem.read <= 1'b0;
					push_valid <= 1'b0;
					state <= frame_pkg::state_idle;
				end
			endcase
		end
	end

	// Capture the word in its completion cycle
	always_ff @(posedge ctrl_clk) begin
		if (read_done)
			push_data <= mem.rdata;
	end

endmodule

`default_nettype wire

/* verilog/frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_store #(
	parameter int FRAME_PIXELS = 64,
	parameter int WAIT_CYCLES = 2
) (
	input wire logic ctrl_clk,
	input wire logic reset_n,
	mem_port_if.store wr,
	mem_port_if.store rd
);

	localparam int AW = $clog2(FRAME_PIXELS);
	localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	frame_pkg::pixel_t mem [FRAME_PIXELS];
	logic [CW-1:0] wait_cnt [2];
	logic [1:0] req;
	logic [1:0] stall;

	// Port 0 is the writer side, port 1 the reader side
	assign req[0] = wr.write | wr.read;
	assign req[1] = rd.write | rd.read;

	always_comb begin
		for (int p = 0; p < 2; p++)
			stall[p] = req[p] && (wait_cnt[p] != CW'(WAIT_CYCLES));
	end

	assign wr.waitrequest = stall[0];
	assign rd.waitrequest = stall[1];

	// Count wait cycles, clear on the completing cycle
	always_ff @(posedge ctrl_clk) begin
		for (int p = 0; p < 2; p++) begin
			if (!reset_n)
				wait_cnt[p] <= '0;
			else if (stall[p])
				wait_cnt[p] <= wait_cnt[p] + 1'b1;
			else if (req[p])
				wait_cnt[p] <= '0;
		end
	end

	// Reader port wins if both write the same word
	always_ff @(posedge ctrl_clk) begin
		if (wr.write && !stall[0])
			mem[wr.addr[AW-1:0]] <= wr.wdata;
		if (rd.write && !stall[1])
			mem[rd.addr[AW-1:0]] <= rd.wdata;
	end

	assign wr.rdata = mem[wr.addr[AW-1:0]];
	assign rd.rdata = mem[rd.addr[AW-1:0]];

endmodule

`default_nettype wire

/* verilog/frame_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_writer #(
	parameter int FRAME_PIXELS = 64
) (
	input wire logic ctrl_clk,
	input wire logic reset_n,
	input wire logic pix_valid,
	input wire frame_pkg::pixel_t pix_data,
	output logic pix_ready,
	mem_port_if.requester mem,
	output logic frame_written
);

	frame_pkg::addr_t addr;
	logic write_done;
	logic last_addr;
	logic take_pixel;

	// Write completes when the store lets go of waitrequest
	assign write_done = mem.write & ~mem.waitrequest;
	assign last_addr = addr == frame_pkg::addr_t'(FRAME_PIXELS - 1);

	// Free when idle, or in the cycle the current write finishes
	assign pix_ready = ~mem.write | write_done;
	assign take_pixel = pix_valid & pix_ready;

	assign mem.addr = addr;
	assign mem.read = 1'b0;

	always_ff @(posedge ctrl_clk) begin
		if (!reset_n) begin
			mem.write <= 1'b0;
			addr <= '0;
			frame_written <= 1'b0;
		end else begin
			frame_written <= 1'b0;

			if (take_pixel)
				mem.write <= 1'b1;
			else if (write_done)
				mem.write <= 1'b0;

			// Step to the next word, wrap at the end of the frame
			if (write_done) begin
				if (last_addr) begin
					addr <= '0;
					frame_written <= 1'b1;
				end else begin
					addr <= addr + 1'b1;
				end
			end
		end
	end

	// Pixel held stable for the whole access
	always_ff @(posedge ctrl_clk) begin
		if (take_pixel)
			mem.wdata <= pix_data;
	end

endmodule

`default_nettype wire

/* verilog/pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input wire logic ctrl_clk,
	input wire logic reset_n,
	input wire logic push_valid,
	input wire frame_pkg::pixel_t push_data,
	output logic push_ready,
	output logic pop_valid,
	output frame_pkg::pixel_t pop_data,
	input wire logic pop_ready,
	output logic [$clog2(FIFO_DEPTH + 1)-1:0] free_words
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	frame_pkg::pixel_t buffer [FIFO_DEPTH];
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	// A full FIFO still takes a word when one leaves in the same cycle
	assign push_ready = (count != CW'(FIFO_DEPTH)) | pop_ready;
	assign pop_valid = count != '0;
	assign pop_data = buffer[rd_ptr];
	assign free_words = CW'(FIFO_DEPTH) - count;

	assign do_push = push_valid & push_ready;
	assign do_pop = pop_valid & pop_ready;

	always_ff @(posedge ctrl_clk) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge ctrl_clk) begin
		if (do_push)
			buffer[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

/* verilog/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One port of the frame store with Avalon-style request and waitrequest
interface mem_port_if;

	frame_pkg::addr_t addr;
	frame_pkg::pixel_t wdata;
	frame_pkg::pixel_t rdata;
	logic write;
	logic read;
	logic waitrequest;

	modport requester (
		output addr,
		output wdata,
		output write,
		output read,
		input rdata,
		input waitrequest
	);

	modport store (
		input addr,
		input wdata,
		input write,
		input read,
		output rdata,
		output waitrequest
	);

endinterface

`default_nettype wire

/* verilog/frame_pkg.sv */
`default_nettype none

package frame_pkg;

	// One pixel word as held in the store
	typedef logic [31:0] pixel_t;

	// Word address into the store for frames up to 65536 pixels
	typedef logic [15:0] addr_t;

	// Frame reader FSM
	typedef enum logic [1:0] {
		state_idle,
		state_request,
		state_advance
	} reader_state_t;

endpackage

`default_nettype wire
